/* memSubsystem.f */
+incdir+rtl
rtl/memPkg.sv
rtl/memoryStage.sv
rtl/storeAlign.sv
rtl/dataMemory.sv
rtl/loadReduce.sv
rtl/writebackStage.sv
rtl/memSubsystem.sv
testbench/memSubsystemTb.sv

/* run.sh */
#!/bin/sh
# Build and run the memSubsystem testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module memSubsystemTb \
    -f memSubsystem.f -o memSubsystemSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/memSubsystemSim > sim.log 2>&1
simStatus=$?
cat sim.log
if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

if grep -qx "ALL TESTS PASSED" sim.log; then
    exit 0
fi
echo "Pass message not found in sim.log"
exit 1

/* testbench/memSubsystemTb.sv */
`default_nettype none
`timescale 1ns/1ps
`include "memStage_consts.svh"

module memSubsystemTb;
    import memPkg::*;

    // Expected values of one pipeline slot
    typedef struct packed {
        logic [`XLEN-1:0]      fwd;
        logic [`XLEN-1:0]      res;
        logic [`REG_IDX_W-1:0] rd;
        logic                  regW;
        logic                  live;
    } slotT;

    logic                  clk = 1'b0;
    logic                  rstN;
    logic                  stallM;
    logic [`XLEN-1:0]      aluResultE, writeDataE, pcTargetE, pcPlus4E, immExtE;
    logic [`REG_IDX_W-1:0] rdE;
    widthSrcT              widthSrcE;
    resultSrcT             resultSrcE;
    logic                  memWriteE, regWriteE;
    logic [`XLEN-1:0]      forwardDataM, resultW;
    logic [`REG_IDX_W-1:0] rdM, rdW;
    logic                  regWriteM, regWriteW;

    // Byte model of the data memory, plus word addresses already written
    logic [7:0]       refMem [1024];
    logic [`XLEN-1:0] knownAddr [$];
    slotT             slotE, slotM, slotW;
    int               errors = 0;
    int               checks = 0;
    int               failedTests = 0;
    int               testErrors = 0;

    memSubsystem u_memSubsystem (.*);

    always #4 clk = ~clk;

    // Two-deep expected queue, moves only on unstalled edges like the DUT
    always @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            slotM <= '0;
            slotW <= '0;
        end else if (!stallM) begin
            slotM <= slotE;
            slotW <= slotM;
        end
    end

    // Applies one instruction to the memory model in program order
    function automatic void modelOp(input logic [31:0] alu, wdata, pct, pc4, imm,
                                    input widthSrcT w, input resultSrcT rs, input logic memW,
                                    output logic [31:0] fwd, output logic [31:0] res);
        logic [9:0]  a;
        logic [31:0] loadVal;
        a = alu[9:0];
        if (memW) begin
            refMem[a] = wdata[7:0];
            if (w != widthByteS && w != widthByteU) begin
                refMem[a + 10'd1] = wdata[15:8];
            end
            if (w == widthWord) begin
                refMem[a + 10'd2] = wdata[23:16];
                refMem[a + 10'd3] = wdata[31:24];
            end
        end
        // Little endian, extension picked by the width code
        case (w)
            widthByteS: loadVal = {{24{refMem[a][7]}}, refMem[a]};
            widthByteU: loadVal = {24'h0, refMem[a]};
            widthHalfS: loadVal = {{16{refMem[a + 10'd1][7]}}, refMem[a + 10'd1], refMem[a]};
            widthHalfU: loadVal = {16'h0, refMem[a + 10'd1], refMem[a]};
            default: loadVal = {refMem[a + 10'd3], refMem[a + 10'd2], refMem[a + 10'd1], refMem[a]};
        endcase
        case (rs)
            resPcTarget: fwd = pct;
            resPcPlus4:  fwd = pc4;
            resImm:      fwd = imm;
            default:     fwd = alu;
        endcase
        res = (rs == resMem) ? loadVal : fwd;
    endfunction

    task automatic compareValue(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error: %s got 0x%08h expected 0x%08h at %0t", name, got, exp, $time);
        end
    endtask

    // Outputs are settled by the falling edge
    always @(negedge clk) begin
        if (rstN) begin
            compareValue("forwardDataM", forwardDataM, slotM.fwd);
            compareValue("rdM", 32'(rdM), 32'(slotM.rd));
            compareValue("regWriteM", 32'(regWriteM), 32'(slotM.regW));
            compareValue("resultW", resultW, slotW.res);
            compareValue("rdW", 32'(rdW), 32'(slotW.rd));
            compareValue("regWriteW", 32'(regWriteW), 32'(slotW.regW));
        end
    end

    // One instruction at E, held there for stallLen stalled edges
    task automatic issueOp(input logic [31:0] alu, wdata, pct, pc4, imm,
                           input logic [4:0] rd, input widthSrcT w, input resultSrcT rs,
                           input logic memW, regW, input int stallLen);
        logic [31:0] fwd;
        logic [31:0] res;
        modelOp(alu, wdata, pct, pc4, imm, w, rs, memW, fwd, res);
        @(posedge clk);
        aluResultE <= alu;
        writeDataE <= wdata;
        pcTargetE  <= pct;
        pcPlus4E   <= pc4;
        immExtE    <= imm;
        rdE        <= rd;
        widthSrcE  <= w;
        resultSrcE <= rs;
        memWriteE  <= memW;
        regWriteE  <= regW;
        slotE      <= '{fwd: fwd, res: res, rd: rd, regW: regW, live: memW | regW};
        stallM     <= (stallLen > 0);
        for (int i = 0; i < stallLen; i++) begin
            @(posedge clk);
        end
        stallM <= 1'b0;
    endtask

    task automatic aluOp(input resultSrcT rs, input int stallLen);
        issueOp($urandom, $urandom, $urandom, $urandom, $urandom, 5'($urandom),
                widthWord, rs, 1'b0, 1'b1, stallLen);
    endtask

    task automatic storeOp(input logic [31:0] addr, data, input widthSrcT w, input int stallLen);
        issueOp(addr, data, $urandom, $urandom, $urandom, 5'($urandom),
                w, resAlu, 1'b1, 1'b0, stallLen);
    endtask

    task automatic loadOp(input logic [31:0] addr, input widthSrcT w, input int stallLen);
        issueOp(addr, $urandom, $urandom, $urandom, $urandom, 5'($urandom),
                w, resMem, 1'b0, 1'b1, stallLen);
    endtask

    // Random width and legal offset inside a word already written
    task automatic randomMemOp(input logic isStore, input int stallLen);
        logic [31:0] addr;
        widthSrcT    w;
        addr = knownAddr[$urandom % knownAddr.size()];
        case ($urandom % 5)
            0: w = widthByteS;
            1: w = widthByteU;
            2: w = widthHalfS;
            3: w = widthHalfU;
            default: w = widthWord;
        endcase
        if (w == widthByteS || w == widthByteU) begin
            addr = addr + ($urandom % 4);
        end else if (w != widthWord) begin
            addr = addr + 2 * ($urandom % 2);
        end
        if (isStore) begin
            storeOp(addr, $urandom, w, stallLen);
        end else begin
            loadOp(addr, w, stallLen);
        end
    endtask

    // Bubbles until the expected queue holds no live instruction
    task automatic drainPipe();
        int guard;
        guard = 0;
        do begin
            issueOp('0, '0, '0, '0, '0, '0, widthWord, resAlu, 1'b0, 1'b0, 0);
            @(negedge clk);
            guard++;
        end while ((slotM.live || slotW.live) && guard < 10);
        if (slotM.live || slotW.live) begin
            errors++;
            $display("Timeout: pipeline did not drain within 10 cycles");
        end
    endtask

    task automatic endTest(input string name);
        if (errors != testErrors) begin
            failedTests++;
        end
        $display("Test %s: %s, %0d errors", name, (errors == testErrors) ? "ok" : "failed",
                 errors - testErrors);
        testErrors = errors;
    endtask

    initial begin
        logic [31:0] addr;
        int          stallLen;
        void'($urandom(32'h7cf8));
        rstN       = 1'b0;
        stallM     = 1'b0;
        // Nonzero E fields while in reset, only the reset keeps the registers clear
        aluResultE = '1;
        writeDataE = '0;
        pcTargetE  = '0;
        pcPlus4E   = '0;
        immExtE    = '0;
        rdE        = '1;
        widthSrcE  = widthWord;
        resultSrcE = resAlu;
        memWriteE  = 1'b0;
        regWriteE  = 1'b1;
        slotE      = '0;
        repeat (5) @(posedge clk);
        rstN       <= 1'b1;
        aluResultE <= '0;
        rdE        <= '0;
        regWriteE  <= 1'b0;
        @(negedge clk);
        compareValue("regWriteM", 32'(regWriteM), '0);
        compareValue("regWriteW", 32'(regWriteW), '0);
        compareValue("resultW", resultW, '0);
        endTest("reset");

        // All four non-memory sources, back to back
        for (int i = 0; i < 24; i++) begin
            aluOp(resultSrcT'(3'(i % 4)), 0);
        end
        drainPipe();
        endTest("forwarding");

        for (int i = 0; i < 8; i++) begin
            addr = ($urandom % 256) << 2;
            storeOp(addr, $urandom, widthWord, 0);
            loadOp(addr, widthWord, 0);
            knownAddr.push_back(addr);
        end
        drainPipe();
        endTest("word store and load");

        // Each lane, then each halfword, read back as a whole word
        addr = knownAddr[0];
        for (int off = 0; off < 4; off++) begin
            storeOp(addr + off, $urandom, (off % 2) ? widthByteU : widthByteS, 0);
            loadOp(addr, widthWord, 0);
        end
        for (int off = 0; off < 4; off += 2) begin
            storeOp(addr + off, $urandom, (off == 0) ? widthHalfS : widthHalfU, 0);
            loadOp(addr, widthWord, 0);
        end
        drainPipe();
        endTest("partial stores");

        // Top bits set and clear in bytes and halfwords, then a random word
        for (int pass = 0; pass < 2; pass++) begin
            storeOp(addr, (pass == 0) ? 32'h7f8081ff : $urandom, widthWord, 0);
            for (int off = 0; off < 4; off++) begin
                loadOp(addr + off, widthByteS, 0);
                loadOp(addr + off, widthByteU, 0);
            end
            for (int off = 0; off < 4; off += 2) begin
                loadOp(addr + off, widthHalfS, 0);
                loadOp(addr + off, widthHalfU, 0);
            end
        end
        drainPipe();
        endTest("load extension");

        for (int i = 0; i < 60; i++) begin
            stallLen = ($urandom % 4 == 0) ? 1 + $urandom % 6 : 0;
            case ($urandom % 4)
                0, 1: aluOp(resultSrcT'(3'($urandom % 4)), stallLen);
                2: randomMemOp(1'b1, stallLen);
                default: randomMemOp(1'b0, stallLen);
            endcase
        end
        drainPipe();
        endTest("stall");

        $display("Tests 6, failed %0d, checks %0d, errors %0d", failedTests, checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* rtl/memSubsystem.sv */
`default_nettype none
`timescale 1ns/1ps
`include "memStage_consts.svh"

module memSubsystem (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  stallM,
    // Execute-stage fields
    input  logic [`XLEN-1:0]      aluResultE,
    input  logic [`XLEN-1:0]      writeDataE,
    input  logic [`XLEN-1:0]      pcTargetE,
    input  logic [`XLEN-1:0]      pcPlus4E,
    input  logic [`XLEN-1:0]      immExtE,
    input  logic [`REG_IDX_W-1:0] rdE,
    input  memPkg::widthSrcT      widthSrcE,
    input  memPkg::resultSrcT     resultSrcE,
    input  logic                  memWriteE,
    input  logic                  regWriteE,
    // Hazard-path view of the M stage
    output logic [`XLEN-1:0]      forwardDataM,
    output logic [`REG_IDX_W-1:0] rdM,
    output logic                  regWriteM,
    // Writeback
    output logic [`XLEN-1:0]      resultW,
    output logic [`REG_IDX_W-1:0] rdW,
    output logic                  regWriteW
);
    import memPkg::*;

    logic [`XLEN-1:0] aluResultM;
    logic [`XLEN-1:0] writeDataM;
    logic [`XLEN-1:0] pcTargetM;
    logic [`XLEN-1:0] pcPlus4M;
    logic [`XLEN-1:0] immExtM;
    widthSrcT         widthSrcM;
    resultSrcT        resultSrcM;
    logic             memWriteM;
    // Store and load paths
    logic [3:0]       byteEnM;
    logic [`XLEN-1:0] alignedDataM;
    logic [`XLEN-1:0] readWordM;
    logic [`XLEN-1:0] reducedDataM;

    memoryStage u_memoryStage (
        .clk          (clk),
        .rstN         (rstN),
        .stallM       (stallM),
        .aluResultE   (aluResultE),
        .writeDataE   (writeDataE),
        .pcTargetE    (pcTargetE),
        .pcPlus4E     (pcPlus4E),
        .immExtE      (immExtE),
        .rdE          (rdE),
        .widthSrcE    (widthSrcE),
        .resultSrcE   (resultSrcE),
        .memWriteE    (memWriteE),
        .regWriteE    (regWriteE),
        .aluResultM   (aluResultM),
        .writeDataM   (writeDataM),
        .pcTargetM    (pcTargetM),
        .pcPlus4M     (pcPlus4M),
        .immExtM      (immExtM),
        .forwardDataM (forwardDataM),
        .rdM          (rdM),
        .widthSrcM    (widthSrcM),
        .resultSrcM   (resultSrcM),
        .memWriteM    (memWriteM),
        .regWriteM    (regWriteM)
    );

    // ALU result is the byte address
    storeAlign u_storeAlign (
        .widthSrc    (widthSrcM),
        .addrLow     (aluResultM[1:0]),
        .storeData   (writeDataM),
        .byteEn      (byteEnM),
        .alignedData (alignedDataM)
    );

    dataMemory u_dataMemory (
        .clk       (clk),
        .memWrite  (memWriteM),
        .addr      (aluResultM),
        .byteEn    (byteEnM),
        .writeData (alignedDataM),
        .readWord  (readWordM)
    );

    loadReduce u_loadReduce (
        .readWord    (readWordM),
        .widthSrc    (widthSrcM),
        .addrLow     (aluResultM[1:0]),
        .reducedData (reducedDataM)
    );

    writebackStage u_writebackStage (
        .clk          (clk),
        .rstN         (rstN),
        .stallM       (stallM),
        .reducedDataM (reducedDataM),
        .aluResultM   (aluResultM),
        .pcTargetM    (pcTargetM),
        .pcPlus4M     (pcPlus4M),
        .immExtM      (immExtM),
        .rdM          (rdM),
        .resultSrcM   (resultSrcM),
        .regWriteM    (regWriteM),
        .resultW      (resultW),
        .rdW          (rdW),
        .regWriteW    (regWriteW)
    );

endmodule

`default_nettype wire

/* rtl/writebackStage.sv */
`default_nettype none
`timescale 1ns/1ps
`include "memStage_consts.svh"

module writebackStage (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  stallM,
    // Memory-stage fields
    input  logic [`XLEN-1:0]      reducedDataM,
    input  logic [`XLEN-1:0]      aluResultM,
    input  logic [`XLEN-1:0]      pcTargetM,
    input  logic [`XLEN-1:0]      pcPlus4M,
    input  logic [`XLEN-1:0]      immExtM,
    input  logic [`REG_IDX_W-1:0] rdM,
    input  memPkg::resultSrcT     resultSrcM,
    input  logic                  regWriteM,
    // Writeback outputs
    output logic [`XLEN-1:0]      resultW,
    output logic [`REG_IDX_W-1:0] rdW,
    output logic                  regWriteW
);
    import memPkg::*;

    logic [`XLEN-1:0] reducedDataW;
    logic [`XLEN-1:0] aluResultW;
    logic [`XLEN-1:0] pcTargetW;
    logic [`XLEN-1:0] pcPlus4W;
    logic [`XLEN-1:0] immExtW;
    resultSrcT        resultSrcW;

    // W register, same hold as the M register
    // Outputs stay stable for the hazard logic during a stall
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            reducedDataW <= '0;
            aluResultW   <= '0;
            pcTargetW    <= '0;
            pcPlus4W     <= '0;
            immExtW      <= '0;
            rdW          <= '0;
            resultSrcW   <= resAlu;
            regWriteW    <= 1'b0;
        end else if (!stallM) begin
            reducedDataW <= reducedDataM;
            aluResultW   <= aluResultM;
            pcTargetW    <= pcTargetM;
            pcPlus4W     <= pcPlus4M;
            immExtW      <= immExtM;
            rdW          <= rdM;
            resultSrcW   <= resultSrcM;
            regWriteW    <= regWriteM;
        end
    end

    // Final result, matches forwarding except for loads
    always_comb begin
        case (resultSrcW)
            resPcTarget: resultW = pcTargetW;
            resPcPlus4:  resultW = pcPlus4W;
            resImm:      resultW = immExtW;
            resMem:      resultW = reducedDataW;
            default:     resultW = aluResultW;
        endcase
    end

endmodule

`default_nettype wire

/* rtl/loadReduce.sv */
`default_nettype none
`timescale 1ns/1ps
`include "memStage_consts.svh"

module loadReduce (
    input  logic [`XLEN-1:0]  readWord,
    input  memPkg::widthSrcT  widthSrc,
    input  logic [1:0]        addrLow,
    output logic [`XLEN-1:0]  reducedData
);
    import memPkg::*;

    logic [7:0]  byteSel;
    logic [15:0] halfSel;

    always_comb begin
        // Lane picked by the address offset
        byteSel = readWord[{addrLow, 3'b000} +: 8];
        // Upper or lower halfword, bit 0 is zero for aligned loads
        halfSel = addrLow[1] ? readWord[31:16] : readWord[15:0];

        case (widthSrc)
            widthByteS: reducedData = {{(`XLEN-8){byteSel[7]}}, byteSel};
            widthByteU: reducedData = {{(`XLEN-8){1'b0}}, byteSel};
            widthHalfS: reducedData = {{(`XLEN-16){halfSel[15]}}, halfSel};
            widthHalfU: reducedData = {{(`XLEN-16){1'b0}}, halfSel};
            // Word load passes straight through
            default:    reducedData = readWord;
        endcase
    end

endmodule

`default_nettype wire

/* rtl/dataMemory.sv */
`default_nettype none
`timescale 1ns/1ps
`include "memStage_consts.svh"

module dataMemory (
    input  logic              clk,
    input  logic              memWrite,
    input  logic [`XLEN-1:0]  addr,
    input  logic [3:0]        byteEn,
    input  logic [`XLEN-1:0]  writeData,
    output logic [`XLEN-1:0]  readWord
);
    localparam int idxW = $clog2(`DMEM_WORDS);

    // Word array, contents undefined after reset
    logic [`XLEN-1:0] mem [`DMEM_WORDS];
    logic [idxW-1:0]  wordIdx;

    // Byte offset bits dropped for word addressing
    assign wordIdx  = addr[idxW+1:2];
    assign readWord = mem[wordIdx];

    // Only enabled lanes are written
    always_ff @(posedge clk) begin
        if (memWrite) begin
            for (int b = 0; b < 4; b++) begin
                if (byteEn[b]) begin
                    mem[wordIdx][8*b +: 8] <= writeData[8*b +: 8];
                end
            end
        end
    end

    // Stores stay inside the array
    writeInRange: assert property (@(posedge clk)
        memWrite |-> (addr[`XLEN-1:idxW+2] == '0));

    // Enables from the aligner form an aligned byte, halfword or word
    writeAligned: assert property (@(posedge clk)
        memWrite |-> (byteEn inside {4'b0001, 4'b0010, 4'b0100, 4'b1000,
                                     4'b0011, 4'b1100, 4'b1111}));

endmodule

`default_nettype wire

/* rtl/storeAlign.sv */
`default_nettype none
`timescale 1ns/1ps
`include "memStage_consts.svh"

module storeAlign (
    input  memPkg::widthSrcT  widthSrc,
    input  logic [1:0]        addrLow,
    input  logic [`XLEN-1:0]  storeData,
    output logic [3:0]        byteEn,
    output logic [`XLEN-1:0]  alignedData
);
    import memPkg::*;

    // Data is copied into every lane, the enables pick the target lane
    // A misaligned offset shifts the enable mask out of shape,
    // which the memory checks on the write strobe
    always_comb begin
        case (widthSrc)
            widthByteS, widthByteU: begin
                alignedData = {4{storeData[7:0]}};
                byteEn      = 4'b0001 << addrLow;
            end
            widthHalfS, widthHalfU: begin
                // Halfword lands in lanes 1:0 or 3:2
                alignedData = {2{storeData[15:0]}};
                byteEn      = 4'b0011 << addrLow;
            end
            default: begin
                // Full word, all lanes when aligned
                alignedData = storeData;
                byteEn      = 4'b1111 << addrLow;
            end
        endcase
    end

endmodule

`default_nettype wire

/* rtl/memoryStage.sv */
`default_nettype none
`timescale 1ns/1ps
`include "memStage_consts.svh"

module memoryStage (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  stallM,
    // Execute-stage data
    input  logic [`XLEN-1:0]      aluResultE,
    input  logic [`XLEN-1:0]      writeDataE,
    input  logic [`XLEN-1:0]      pcTargetE,
    input  logic [`XLEN-1:0]      pcPlus4E,
    input  logic [`XLEN-1:0]      immExtE,
    input  logic [`REG_IDX_W-1:0] rdE,
    // Execute-stage control
    input  memPkg::widthSrcT      widthSrcE,
    input  memPkg::resultSrcT     resultSrcE,
    input  logic                  memWriteE,
    input  logic                  regWriteE,
    // Memory-stage data
    output logic [`XLEN-1:0]      aluResultM,
    output logic [`XLEN-1:0]      writeDataM,
    output logic [`XLEN-1:0]      pcTargetM,
    output logic [`XLEN-1:0]      pcPlus4M,
    output logic [`XLEN-1:0]      immExtM,
    output logic [`XLEN-1:0]      forwardDataM,
    output logic [`REG_IDX_W-1:0] rdM,
    // Memory-stage control
    output memPkg::widthSrcT      widthSrcM,
    output memPkg::resultSrcT     resultSrcM,
    output logic                  memWriteM,
    output logic                  regWriteM
);
    import memPkg::*;

    // M pipeline register, frozen while stallM is high
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            aluResultM <= '0;
            writeDataM <= '0;
            pcTargetM  <= '0;
            pcPlus4M   <= '0;
            immExtM    <= '0;
            rdM        <= '0;
            widthSrcM  <= widthWord;
            resultSrcM <= resAlu;
            // No store or register write out of reset
            memWriteM  <= 1'b0;
            regWriteM  <= 1'b0;
        end else if (!stallM) begin
            aluResultM <= aluResultE;
            writeDataM <= writeDataE;
            pcTargetM  <= pcTargetE;
            pcPlus4M   <= pcPlus4E;
            immExtM    <= immExtE;
            rdM        <= rdE;
            widthSrcM  <= widthSrcE;
            resultSrcM <= resultSrcE;
            memWriteM  <= memWriteE;
            regWriteM  <= regWriteE;
        end
    end

    // Forwarding value for the hazard path
    // resMem aliases to the ALU result, load-use is stalled upstream
    always_comb begin
        case (resultSrcM[1:0])
            2'b00:   forwardDataM = aluResultM;
            2'b01:   forwardDataM = pcTargetM;
            2'b10:   forwardDataM = pcPlus4M;
            default: forwardDataM = immExtM;
        endcase
    end

    // A store never also writes back load data
    storeNotLoad: assert property (@(posedge clk) disable iff (!rstN)
        !(memWriteM && resultSrcM == resMem));

    // Loads and stores sit on their natural boundary
    accessAligned: assert property (@(posedge clk) disable iff (!rstN)
        (memWriteM || resultSrcM == resMem) |->
            ((widthSrcM[1:0] == 2'b00) ? (aluResultM[1:0] == 2'b00) :
             (widthSrcM[1:0] == 2'b10) ? !aluResultM[0] : 1'b1));

endmodule

`default_nettype wire

/* rtl/memPkg.sv */
`default_nettype none

// Shared encodings for the memory-access slice
package memPkg;

    // Access width of a load or store
    // Bits 1:0 give the size (00 word, 01 byte, 10 halfword)
    // Bit 2 set means zero extension on loads
    // Stores look at the size only
    typedef enum logic [2:0] {
        widthWord  = 3'b000,
        widthByteS = 3'b001,
        widthHalfS = 3'b010,
        widthByteU = 3'b101,
        widthHalfU = 3'b110
    } widthSrcT;

    // Value written back to the register file
    // Codes 0 to 3 double as the forwarding mux select
    typedef enum logic [2:0] {
        resAlu      = 3'b000,
        resPcTarget = 3'b001,
        resPcPlus4  = 3'b010,
        resImm      = 3'b011,
        resMem      = 3'b100
    } resultSrcT;

endpackage

`default_nettype wire

/* rtl/memStage_consts.svh */
`ifndef MEM_STAGE_CONSTS_SVH
`define MEM_STAGE_CONSTS_SVH

// Data and address width
`define XLEN 32

// Register index width
`define REG_IDX_W 5

// Data memory depth in 32-bit words
// 256 words, indexed by address bits 9 to 2
`define DMEM_WORDS 256

`endif
